/* mul_unit.f */
+incdir+.
mul_types_pkg.sv
mul_uop_pkg.sv
mul_issue.sv
mul_pipeline.sv
mul_result_fifo.sv
mul_writeback.sv
mul_unit.sv
mul_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the multiply unit testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 \
  --top-module mul_unit_tb -f mul_unit.f -o mul_unit_sim &&
  { ./obj_dir/mul_unit_sim > sim.log 2>&1 || true; } &&
  cat sim.log &&
  grep -qx "Test OK" sim.log ||
  { echo "Simulation did not pass, see sim.log"; exit 1; }

exit 0

/* mul_unit_tb.sv */
/*
 * Multiply unit testbench
 * Directed tests plus an LCG stream, checked in order against a
 * reference multiply model through a scoreboard
 */

`timescale 1ns/10ps
`default_nettype none

`include "mul_settings.svh"

module mul_unit_tb
  import mul_types_pkg::*;
  import mul_uop_pkg::*;
();

  localparam int RAND_MSGS   = 200;
  // Fixed tests stay under 300 cycles, random stream near two per message
  localparam int CYCLE_LIMIT = 400 + 8 * RAND_MSGS;

  logic      clk = 1'b0;
  logic      reset;
  logic      in_val;
  logic      in_rdy;
  word_t     in_pc;
  seq_num_t  in_seq_num;
  word_t     in_op1;
  word_t     in_op2;
  reg_addr_t in_waddr;
  mul_op_t   in_uop;
  logic      out_val;
  logic      out_rdy;
  word_t     out_pc;
  seq_num_t  out_seq_num;
  reg_addr_t out_waddr;
  word_t     out_wdata;
  logic      out_wen;

  // Scoreboard, filled on accept
  word_t     exp_pc_q[$];
  seq_num_t  exp_seq_q[$];
  reg_addr_t exp_waddr_q[$];
  word_t     exp_wdata_q[$];
  logic      exp_wen_q[$];

  string       test_name = "reset";
  int          cycle_count = 0;
  logic        rdy_random = 1'b0;
  logic [31:0] lcg_state = 32'd53;

  // Directed operand pairs
  word_t dir_a[3] = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h1234_5678};
  word_t dir_b[3] = '{32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h9ABC_DEF0};

  mul_unit DUT (.*);

  always #2 clk = ~clk;

  //--------------------
  // Helpers
  //--------------------

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Reference RV32M multiply in 64-bit arithmetic
  function automatic word_t ref_mul(input word_t op1, input word_t op2, input mul_op_t op);
    op_signs_t   signs;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] p;
    signs = mul_op_signs(op);
    a = signs[1] ? {{32{op1[31]}}, op1} : {32'b0, op1};
    b = signs[0] ? {{32{op2[31]}}, op2} : {32'b0, op2};
    p = a * b;
    return (op == MUL_LO) ? p[31:0] : p[63:32];
  endfunction

  task automatic check_eq(input string field, input logic [63:0] expected,
                          input logic [63:0] actual);
    if (expected !== actual) begin
      $display("Mismatch in %s, %s: expected %0h, actual %0h",
               test_name, field, expected, actual);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  // Called on a falling edge, returns on the falling edge after the accept
  task automatic send_msg(input word_t pc, input seq_num_t seq, input word_t op1,
                          input word_t op2, input reg_addr_t waddr, input mul_op_t op);
    logic        done;
    logic [31:0] r;
    done = 1'b0;
    in_val     = 1'b1;
    in_pc      = pc;
    in_seq_num = seq;
    in_op1     = op1;
    in_op2     = op2;
    in_waddr   = waddr;
    in_uop     = op;
    while (!done) begin
      if (rdy_random) begin
        r = lcg_next();
        out_rdy = r[20];
      end
      // in_rdy only moves on a rising edge, so this predicts the transfer
      if (in_rdy) begin
        exp_pc_q.push_back(pc);
        exp_seq_q.push_back(seq);
        exp_waddr_q.push_back(waddr);
        exp_wdata_q.push_back(ref_mul(op1, op2, op));
        exp_wen_q.push_back(waddr != 5'd0);
        done = 1'b1;
      end
      @(negedge clk);
    end
  endtask

  task automatic wait_drain();
    logic [31:0] r;
    in_val = 1'b0;
    while (exp_pc_q.size() != 0) begin
      if (rdy_random) begin
        r = lcg_next();
        out_rdy = r[20];
      end
      @(negedge clk);
    end
  endtask

  //--------------------
  // Monitor and timeout
  //--------------------

  always @(posedge clk) begin
    if (!reset && out_val && out_rdy) begin
      if (exp_pc_q.size() == 0) begin
        $display("Writeback message seen with nothing outstanding in %s", test_name);
        $display("Test FAILED");
        $fatal(1);
      end else begin
        check_eq("pc", 64'(exp_pc_q.pop_front()), 64'(out_pc));
        check_eq("seq_num", 64'(exp_seq_q.pop_front()), 64'(out_seq_num));
        check_eq("waddr", 64'(exp_waddr_q.pop_front()), 64'(out_waddr));
        check_eq("wdata", 64'(exp_wdata_q.pop_front()), 64'(out_wdata));
        check_eq("wen", 64'(exp_wen_q.pop_front()), 64'(out_wen));
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout in %s after %0d cycles, DUT stopped responding",
               test_name, cycle_count);
      $display("Test FAILED");
      $fatal(1);
    end
  end

  //--------------------
  // Tests
  //--------------------

  task automatic test_after_reset();
    test_name = "after_reset";
    check_eq("in_rdy", 64'(1'b1), 64'(in_rdy));
    check_eq("out_val", 64'(1'b0), 64'(out_val));
  endtask

  task automatic test_directed_ops();
    test_name = "directed_ops";
    // Known answers keep the model honest
    check_eq("model mulhu", 64'(32'hFFFF_FFFE),
             64'(ref_mul(32'hFFFF_FFFF, 32'hFFFF_FFFF, MULH_UU)));
    check_eq("model mulh", 64'(32'h0), 64'(ref_mul(32'hFFFF_FFFF, 32'hFFFF_FFFF, MULH_SS)));
    check_eq("model mulhsu", 64'(32'h8000_0000),
             64'(ref_mul(32'h8000_0000, 32'hFFFF_FFFF, MULH_SU)));
    check_eq("model mul", 64'(32'h8000_0000),
             64'(ref_mul(32'h8000_0000, 32'hFFFF_FFFF, MUL_LO)));
    out_rdy = 1'b1;
    for (int i = 0; i < 3; i++) begin
      for (int k = 0; k < 4; k++) begin
        send_msg(word_t'(32'h1000 + 16 * i + 4 * k), seq_num_t'(4 * i + k),
                 dir_a[i], dir_b[i], reg_addr_t'(4 * i + k + 1), mul_op_t'(k));
      end
    end
    wait_drain();
  endtask

  task automatic test_write_enable();
    test_name = "write_enable";
    out_rdy = 1'b1;
    // x0 target still carries data, just no write
    send_msg(32'h2000, 5'd20, 32'd3, 32'd5, 5'd0, MUL_LO);
    send_msg(32'h2004, 5'd21, 32'hFFFF_FFFD, 32'd5, 5'd31, MULH_SU);
    wait_drain();
  endtask

  task automatic test_idle_latency();
    int lat;
    test_name = "idle_latency";
    out_rdy = 1'b1;
    send_msg(32'h3000, 5'd9, 32'd1234, 32'd5678, 5'd7, MUL_LO);
    in_val = 1'b0;
    @(posedge clk);
    lat = 1;
    @(negedge clk);
    while (!out_val) begin
      @(posedge clk);
      lat++;
      @(negedge clk);
    end
    check_eq("latency", 64'(3), 64'(lat));
    wait_drain();
  endtask

  task automatic test_back_pressure();
    int n_acc;
    test_name = "back_pressure";
    out_rdy = 1'b0;
    n_acc = 0;
    while (in_rdy && n_acc < 2 * `MUL_FIFO_DEPTH) begin
      send_msg(word_t'(32'h4000 + 4 * n_acc), seq_num_t'(n_acc),
               word_t'(32'hF000_0001 + n_acc), 32'h7FFF_FFFF,
               reg_addr_t'(n_acc + 3), mul_op_t'(n_acc % 4));
      n_acc++;
    end
    in_val = 1'b0;
    check_eq("accepted", 64'(`MUL_FIFO_DEPTH), 64'(n_acc));
    // Held results must stay put and block issue
    repeat (6) @(negedge clk);
    check_eq("in_rdy held", 64'(1'b0), 64'(in_rdy));
    check_eq("out_val held", 64'(1'b1), 64'(out_val));
    out_rdy = 1'b1;
    wait_drain();
  endtask

  task automatic test_random_stream();
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    test_name = "random_stream";
    rdy_random = 1'b1;
    for (int i = 0; i < RAND_MSGS; i++) begin
      r1 = lcg_next();
      r2 = lcg_next();
      r3 = lcg_next();
      send_msg(word_t'(32'h8000 + 4 * i), seq_num_t'(i), r1, r2,
               reg_addr_t'(r3[12:8]), mul_op_t'(r3[17:16]));
    end
    wait_drain();
    rdy_random = 1'b0;
    out_rdy = 1'b1;
  endtask

  //--------------------
  // Main sequence
  //--------------------

  initial begin
    reset      = 1'b1;
    in_val     = 1'b0;
    in_pc      = '0;
    in_seq_num = '0;
    in_op1     = '0;
    in_op2     = '0;
    in_waddr   = '0;
    in_uop     = MUL_LO;
    out_rdy    = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    test_after_reset();
    test_directed_ops();
    test_write_enable();
    test_idle_latency();
    test_back_pressure();
    test_random_stream();

    test_name = "end_of_run";
    repeat (4) @(negedge clk);
    check_eq("out_val idle", 64'(1'b0), 64'(out_val));
    check_eq("in_rdy idle", 64'(1'b1), 64'(in_rdy));
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

/* mul_unit.sv */
/*
 * Multiply execute unit
 * Issue, two-stage multiplier, result buffer and writeback, in that order
 */

`timescale 1ns/10ps
`default_nettype none

module mul_unit
  import mul_types_pkg::*;
  import mul_uop_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  // Decode side
  input  logic      in_val,
  output logic      in_rdy,
  input  word_t     in_pc,
  input  seq_num_t  in_seq_num,
  input  word_t     in_op1,
  input  word_t     in_op2,
  input  reg_addr_t in_waddr,
  input  mul_op_t   in_uop,

  // Writeback side
  output logic      out_val,
  input  logic      out_rdy,
  output word_t     out_pc,
  output seq_num_t  out_seq_num,
  output reg_addr_t out_waddr,
  output word_t     out_wdata,
  output logic      out_wen
);

  // Issue to core
  logic      iss_val;
  word_t     iss_pc;
  seq_num_t  iss_seq_num;
  reg_addr_t iss_waddr;
  logic      iss_hi;
  opnd_t     iss_a;
  opnd_t     iss_b;

  // Core to buffer
  logic      mp_val;
  word_t     mp_pc;
  seq_num_t  mp_seq_num;
  reg_addr_t mp_waddr;
  logic      mp_hi;
  prod_t     mp_prod;

  // Buffer to writeback, and the credit loop
  logic      fifo_val;
  word_t     fifo_pc;
  seq_num_t  fifo_seq_num;
  reg_addr_t fifo_waddr;
  logic      fifo_hi;
  prod_t     fifo_prod;
  logic      fifo_pop;
  logic      credit_ret;

  // All ports match the wire names above
  mul_issue u_issue (.*);

  mul_pipeline u_pipeline (.*);

  mul_result_fifo u_result_fifo (.*);

  mul_writeback u_writeback (.*);

endmodule

`default_nettype wire

/* mul_writeback.sv */
/*
 * Multiply writeback
 * Picks the product half, forms the write enable, drives the output port
 */

`timescale 1ns/10ps
`default_nettype none

`include "mul_settings.svh"

module mul_writeback
  import mul_types_pkg::*;
(
  // Only the stability check looks at these
  input  logic      clk,
  input  logic      reset,

  // Buffer head
  input  logic      fifo_val,
  input  word_t     fifo_pc,
  input  seq_num_t  fifo_seq_num,
  input  reg_addr_t fifo_waddr,
  input  logic      fifo_hi,
  input  prod_t     fifo_prod,
  output logic      fifo_pop,

  // Writeback port
  output logic      out_val,
  input  logic      out_rdy,
  output word_t     out_pc,
  output seq_num_t  out_seq_num,
  output reg_addr_t out_waddr,
  output word_t     out_wdata,
  output logic      out_wen
);

  assign out_val     = fifo_val;
  assign out_pc      = fifo_pc;
  assign out_seq_num = fifo_seq_num;
  assign out_waddr   = fifo_waddr;

  // MULH* take the upper word
  assign out_wdata = fifo_hi ? fifo_prod[2*`MUL_XLEN-1:`MUL_XLEN]
                             : fifo_prod[`MUL_XLEN-1:0];

  // x0 is never written
  assign out_wen = (fifo_waddr != '0);

  // Head leaves on a completed transfer
  assign fifo_pop = out_val && out_rdy;

  // Held message must not change until taken
  out_stable: assert property (
    @(posedge clk) disable iff (reset)
    out_val && !out_rdy |=> out_val && $stable({out_pc, out_seq_num, out_waddr,
                                                out_wdata, out_wen})
  );

endmodule

`default_nettype wire

/* mul_result_fifo.sv */
/*
 * Multiply result buffer
 * Circular buffer of finished products, one credit returned per pop
 */

`timescale 1ns/10ps
`default_nettype none

`include "mul_settings.svh"

module mul_result_fifo
  import mul_types_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  // Write side from the multiplier core
  input  logic      mp_val,
  input  word_t     mp_pc,
  input  seq_num_t  mp_seq_num,
  input  reg_addr_t mp_waddr,
  input  logic      mp_hi,
  input  prod_t     mp_prod,

  // Read side to writeback
  input  logic      fifo_pop,
  output logic      fifo_val,
  output word_t     fifo_pc,
  output seq_num_t  fifo_seq_num,
  output reg_addr_t fifo_waddr,
  output logic      fifo_hi,
  output prod_t     fifo_prod,

  // Back to issue
  output logic      credit_ret
);

  localparam int PTR_BITS = $clog2(`MUL_FIFO_DEPTH);

  // Storage
  word_t     pc_mem   [`MUL_FIFO_DEPTH];
  seq_num_t  seq_mem  [`MUL_FIFO_DEPTH];
  reg_addr_t waddr_mem[`MUL_FIFO_DEPTH];
  logic      hi_mem   [`MUL_FIFO_DEPTH];
  prod_t     prod_mem [`MUL_FIFO_DEPTH];

  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [PTR_BITS:0]   count;

  // Head entry
  assign fifo_val     = (count != '0);
  assign fifo_pc      = pc_mem[rd_ptr];
  assign fifo_seq_num = seq_mem[rd_ptr];
  assign fifo_waddr   = waddr_mem[rd_ptr];
  assign fifo_hi      = hi_mem[rd_ptr];
  assign fifo_prod    = prod_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (mp_val) begin
      pc_mem[wr_ptr]    <= mp_pc;
      seq_mem[wr_ptr]   <= mp_seq_num;
      waddr_mem[wr_ptr] <= mp_waddr;
      hi_mem[wr_ptr]    <= mp_hi;
      prod_mem[wr_ptr]  <= mp_prod;
    end
  end

  //--------------------
  // Pointers and count
  //--------------------

  // Depth is a power of two, pointers wrap on their own
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      credit_ret <= 1'b0;
    end else begin
      if (mp_val) wr_ptr <= wr_ptr + 1'b1;
      if (fifo_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({mp_val, fifo_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      credit_ret <= fifo_pop;
    end
  end

  // Issue credits must keep the core from overrunning the buffer
  no_overflow: assert property (
    @(posedge clk) disable iff (reset) mp_val |-> (count < `MUL_FIFO_DEPTH)
  );

  // Writeback only pops a valid head
  no_underflow: assert property (
    @(posedge clk) disable iff (reset) fifo_pop |-> (count != '0)
  );

endmodule

`default_nettype wire

/* mul_pipeline.sv */
/*
 * Multiplier core
 * Two-stage signed 33x33 multiply, message fields ride alongside
 */

`timescale 1ns/10ps
`default_nettype none

`include "mul_settings.svh"

module mul_pipeline
  import mul_types_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  // From issue
  input  logic      iss_val,
  input  word_t     iss_pc,
  input  seq_num_t  iss_seq_num,
  input  reg_addr_t iss_waddr,
  input  logic      iss_hi,
  input  opnd_t     iss_a,
  input  opnd_t     iss_b,

  // To the result buffer
  output logic      mp_val,
  output word_t     mp_pc,
  output seq_num_t  mp_seq_num,
  output reg_addr_t mp_waddr,
  output logic      mp_hi,
  output prod_t     mp_prod
);

  // Split point of operand b
  localparam int LO_BITS   = `MUL_XLEN / 2;
  // 33-bit a times a 17-bit signed slice
  localparam int PART_BITS = (`MUL_XLEN + 1) + (`MUL_XLEN + 1 - LO_BITS);

  logic                        s1_val;
  word_t                       s1_pc;
  seq_num_t                    s1_seq_num;
  reg_addr_t                   s1_waddr;
  logic                        s1_hi;
  logic signed [PART_BITS-1:0] s1_part_lo;
  logic signed [PART_BITS-1:0] s1_part_hi;
  prod_t                       s2_sum;

  //--------------------
  // Valid chain
  //--------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_val <= 1'b0;
      mp_val <= 1'b0;
    end else begin
      s1_val <= iss_val;
      mp_val <= s1_val;
    end
  end

  //--------------------
  // Stage one
  //--------------------

  // Low slice is zero extended so it stays positive
  always_ff @(posedge clk) begin
    if (iss_val) begin
      s1_pc      <= iss_pc;
      s1_seq_num <= iss_seq_num;
      s1_waddr   <= iss_waddr;
      s1_hi      <= iss_hi;
      s1_part_lo <= $signed(iss_a) * $signed({1'b0, iss_b[LO_BITS-1:0]});
      s1_part_hi <= $signed(iss_a) * $signed(iss_b[`MUL_XLEN:LO_BITS]);
    end
  end

  //--------------------
  // Stage two
  //--------------------

  // Sign extend both partials, weight the upper one, add mod 2^64
  assign s2_sum = prod_t'(s1_part_lo) + (prod_t'(s1_part_hi) << LO_BITS);

  always_ff @(posedge clk) begin
    if (s1_val) begin
      mp_pc      <= s1_pc;
      mp_seq_num <= s1_seq_num;
      mp_waddr   <= s1_waddr;
      mp_hi      <= s1_hi;
      mp_prod    <= s2_sum;
    end
  end

endmodule

`default_nettype wire

/* mul_issue.sv */
/*
 * Multiply issue stage
 * Accepts decode messages against result buffer credits, extends the
 * operands to 33 bits and registers them for the multiplier core
 */

`timescale 1ns/10ps
`default_nettype none

`include "mul_settings.svh"

module mul_issue
  import mul_types_pkg::*;
  import mul_uop_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  // Decode side
  input  logic      in_val,
  output logic      in_rdy,
  input  word_t     in_pc,
  input  seq_num_t  in_seq_num,
  input  word_t     in_op1,
  input  word_t     in_op2,
  input  reg_addr_t in_waddr,
  input  mul_op_t   in_uop,

  // One pulse per result buffer pop
  input  logic      credit_ret,

  // To the multiplier core
  output logic      iss_val,
  output word_t     iss_pc,
  output seq_num_t  iss_seq_num,
  output reg_addr_t iss_waddr,
  output logic      iss_hi,
  output opnd_t     iss_a,
  output opnd_t     iss_b
);

  credit_t credits;
  logic    accept;
  logic    op1_signed;
  logic    op2_signed;

  // Ready only depends on credits, never on in_val
  assign in_rdy = (credits != '0);
  assign accept = in_val && in_rdy;

  assign {op1_signed, op2_signed} = mul_op_signs(in_uop);

  //--------------------
  // Credit counter
  //--------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= credit_t'(`MUL_FIFO_DEPTH);
    end else begin
      case ({accept, credit_ret})
        2'b10:   credits <= credits - credit_t'(1);
        2'b01:   credits <= credits + credit_t'(1);
        // Accept and return together cancel out
        default: credits <= credits;
      endcase
    end
  end

  //--------------------
  // Issue register
  //--------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      iss_val <= 1'b0;
    end else begin
      iss_val <= accept;
    end
  end

  // Payload only loads on a transfer
  always_ff @(posedge clk) begin
    if (accept) begin
      iss_pc      <= in_pc;
      iss_seq_num <= in_seq_num;
      iss_waddr   <= in_waddr;
      iss_hi      <= (in_uop != MUL_LO);
      // Extra top bit is a copy of the sign or a zero
      iss_a       <= {op1_signed & in_op1[`MUL_XLEN-1], in_op1};
      iss_b       <= {op2_signed & in_op2[`MUL_XLEN-1], in_op2};
    end
  end

  // Returns must never outnumber the buffer entries handed out
  credit_bound: assert property (
    @(posedge clk) disable iff (reset) credits <= `MUL_FIFO_DEPTH
  );

endmodule

`default_nettype wire

/* mul_uop_pkg.sv */
/*
 * Multiply micro-ops
 * Op encoding and the per-op operand signedness lookup
 */

`default_nettype none

package mul_uop_pkg;

  // RV32M multiply flavours
  typedef enum logic [1:0] {
    MUL_LO  = 2'd0,
    MULH_SS = 2'd1,
    MULH_SU = 2'd2,
    MULH_UU = 2'd3
  } mul_op_t;

  // Bit 1 is op1 signed, bit 0 is op2 signed
  typedef logic [1:0] op_signs_t;

  // Low half is the same either way, so MUL_LO takes the signed path
  function automatic op_signs_t mul_op_signs(input mul_op_t op);
    case (op)
      MUL_LO:  mul_op_signs = 2'b11;
      MULH_SS: mul_op_signs = 2'b11;
      MULH_SU: mul_op_signs = 2'b10;
      default: mul_op_signs = 2'b00;
    endcase
  endfunction

endpackage

`default_nettype wire

/* mul_types_pkg.sv */
/*
 * Multiply unit data types
 * Plain vectors for words, register addresses, sequence numbers and products
 */

`default_nettype none

`include "mul_settings.svh"

package mul_types_pkg;

  // Data word, also used for the pc
  typedef logic [`MUL_XLEN-1:0] word_t;

  // Architectural register index
  typedef logic [`MUL_REG_BITS-1:0] reg_addr_t;

  // In-order tag from decode
  typedef logic [`MUL_SEQ_BITS-1:0] seq_num_t;

  // Operand after sign or zero extension, one extra bit
  typedef logic [`MUL_XLEN:0] opnd_t;

  // Full product, high and low halves
  typedef logic [2*`MUL_XLEN-1:0] prod_t;

  // Result buffer credits held by issue
  typedef logic [`MUL_CREDIT_BITS-1:0] credit_t;

endpackage

`default_nettype wire

/* mul_settings.svh */
/*
 * Multiply unit settings
 * Widths, pipeline depth and result buffer sizing
 */

`ifndef MUL_SETTINGS_SVH
`define MUL_SETTINGS_SVH

// Data path
`define MUL_XLEN        32
`define MUL_REG_BITS    5
`define MUL_SEQ_BITS    5

// Registered stages inside the multiplier core
`define MUL_PIPE_DEPTH  2

// Result buffer entries, also the initial credit count
`define MUL_FIFO_DEPTH  4
`define MUL_CREDIT_BITS 3

`endif
